// ==== rtl/rob_defines.svh ====
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// Window depth, must be a power of two
`define ROB_LENGTH 16

// Completions accepted and instructions retired per cycle
`define ROB_WIDTH 2

// Window may span at most half of the sequence-number range
`define SQN_BITS 6

`define TAG_BITS 6
`define NAME_BITS 5

`endif

// ==== rtl/robPkg.sv ====
package robPkg;
    `include "rob_defines.svh"

    // Finished instruction as reported by execution
    typedef struct packed {
        logic                  valid;
        logic                  flag;
        logic [`TAG_BITS-1:0]  tag;
        logic [`NAME_BITS-1:0] name;
        logic [`SQN_BITS-1:0]  sqN;
    } completion;

    // Window slot, sqN is implied by slot position
    typedef struct packed {
        logic                  valid;
        logic                  flag;
        logic [`TAG_BITS-1:0]  tag;
        logic [`NAME_BITS-1:0] name;
    } robEntry;

    typedef struct packed {
        logic                  valid;
        logic [`NAME_BITS-1:0] name;
        logic [`TAG_BITS-1:0]  tag;
        logic [`SQN_BITS-1:0]  sqN;
    } commitSlot;

    typedef enum logic {robRun, robHalted} robMode;
    typedef enum logic [1:0] {retNone, retSingle, retDual} retireKind;

    // Wrap-around compare, true when a comes after b in program order
    function automatic logic isYounger(logic [`SQN_BITS-1:0] a, logic [`SQN_BITS-1:0] b);
        logic [`SQN_BITS-1:0] diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction
endpackage

// ==== rtl/resultIntake.sv ====
`timescale 1ns/100ps
`include "rob_defines.svh"

module resultIntake import robPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  completion            done [`ROB_WIDTH],
    input  logic                 squash,
    input  logic [`SQN_BITS-1:0] squashSqN,
    output completion            staged [`ROB_WIDTH]
);

    completion held [`ROB_WIDTH];
    logic      dropIn [`ROB_WIDTH];

    // Incoming lanes beyond the squash point never get captured
    always_comb begin
        for (int l = 0; l < `ROB_WIDTH; l++) begin
            dropIn[l] = squash && isYounger(done[l].sqN, squashSqN);
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < `ROB_WIDTH; l++) begin
            held[l] <= done[l];
            if (rst) begin
                held[l].valid <= 1'b0;
            end else begin
                held[l].valid <= done[l].valid && !dropIn[l];
            end
        end
    end

    // Held lanes are masked in the squash cycle itself,
    // the buffer writes them on the same edge
    always_comb begin
        for (int l = 0; l < `ROB_WIDTH; l++) begin
            staged[l] = held[l];
            staged[l].valid = held[l].valid
                && !(squash && isYounger(held[l].sqN, squashSqN));
        end
    end

    // Source must never report one sqN on two lanes
    for (genvar a = 0; a < `ROB_WIDTH; a++) begin : gDupA
        for (genvar b = a + 1; b < `ROB_WIDTH; b++) begin : gDupB
            assert property (@(posedge clk) disable iff (rst)
                (done[a].valid && done[b].valid) |-> (done[a].sqN != done[b].sqN))
            else $error("duplicate sqN on completion lanes %0d and %0d", a, b);
        end
    end

endmodule

// ==== rtl/reorderBuffer.sv ====
`timescale 1ns/100ps
`include "rob_defines.svh"

module reorderBuffer import robPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  completion            staged [`ROB_WIDTH],
    input  logic                 squash,
    input  logic [`SQN_BITS-1:0] squashSqN,
    output commitSlot            commit [`ROB_WIDTH],
    output logic [`SQN_BITS-1:0] curSqN,
    output logic [`SQN_BITS-1:0] maxSqN,
    output logic                 halted
);

    localparam int IdxBits = $clog2(`ROB_LENGTH);

    robEntry              entries [`ROB_LENGTH];
    logic [`SQN_BITS-1:0] base;
    logic [`SQN_BITS-1:0] nextBase;
    robMode               mode;
    retireKind            kind;
    logic [1:0]           numRet;

    assign curSqN = base;
    assign maxSqN = base + `SQN_BITS'(`ROB_LENGTH - 1);
    assign halted = (mode == robHalted);

    // Retire choice for this cycle
    always_comb begin
        kind = retNone;
        if (!squash && mode == robRun && entries[0].valid) begin
            if (!entries[0].flag && entries[1].valid && !entries[1].flag) begin
                kind = retDual;
            end else begin
                kind = retSingle;
            end
        end
    end

    always_comb begin
        case (kind)
            retDual:   numRet = 2'd2;
            retSingle: numRet = 2'd1;
            default:   numRet = 2'd0;
        endcase
    end

    // Base after this edge, used to place incoming completions
    always_comb begin
        if (squash) begin
            nextBase = isYounger(base, squashSqN) ? squashSqN : base;
        end else begin
            nextBase = base + `SQN_BITS'(numRet);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            base <= '0;
            mode <= robRun;
            for (int i = 0; i < `ROB_LENGTH; i++) begin
                entries[i].valid <= 1'b0;
            end
            for (int l = 0; l < `ROB_WIDTH; l++) begin
                commit[l].valid <= 1'b0;
            end
        end else begin
            for (int l = 0; l < `ROB_WIDTH; l++) begin
                commit[l].valid <= (l < numRet);
                commit[l].name  <= entries[l].name;
                commit[l].tag   <= entries[l].tag;
                commit[l].sqN   <= base + `SQN_BITS'(l);
            end

            if (squash) begin
                // Drop everything past the squash point
                for (int i = 0; i < `ROB_LENGTH; i++) begin
                    if (isYounger(base + `SQN_BITS'(i), squashSqN)) begin
                        entries[i].valid <= 1'b0;
                    end
                end
            end else if (numRet != 2'd0) begin
                for (int i = 0; i < `ROB_LENGTH; i++) begin
                    if (i + numRet < `ROB_LENGTH) begin
                        entries[i] <= entries[i + numRet];
                    end else begin
                        entries[i].valid <= 1'b0;
                    end
                end
                // Flagged head retires alone and stops the window
                if (kind == retSingle && entries[0].flag) begin
                    mode <= robHalted;
                end
            end
            base <= nextBase;

            // Enqueue after the shift so new slots win
            for (int l = 0; l < `ROB_WIDTH; l++) begin
                if (staged[l].valid) begin
                    entries[IdxBits'(staged[l].sqN - nextBase)] <= '{
                        valid: 1'b1,
                        flag:  staged[l].flag,
                        tag:   staged[l].tag,
                        name:  staged[l].name
                    };
                end
            end
        end
    end

    // Completion source stays inside the current window
    for (genvar l = 0; l < `ROB_WIDTH; l++) begin : gWin
        assert property (@(posedge clk) disable iff (rst)
            staged[l].valid |-> (`SQN_BITS'(staged[l].sqN - base) < `ROB_LENGTH))
        else $error("staged lane %0d sqN %0d outside window", l, staged[l].sqN);
    end

    // Nothing may retire once the halt has been seen
    assert property (@(posedge clk) disable iff (rst)
        (mode == robHalted) |=> !commit[0].valid)
    else $error("commit while halted");

endmodule

// ==== rtl/commitMap.sv ====
`timescale 1ns/100ps
`include "rob_defines.svh"

module commitMap import robPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  commitSlot             commit [`ROB_WIDTH],
    input  logic [`NAME_BITS-1:0] readName,
    output logic [`TAG_BITS-1:0]  readTag,
    output logic [31:0]           retiredCount
);

    localparam int NumNames = 2 ** `NAME_BITS;

    logic [`TAG_BITS-1:0] archMap [NumNames];
    logic [31:0]          laneCount;

    // Valid lanes this cycle
    always_comb begin
        laneCount = '0;
        for (int l = 0; l < `ROB_WIDTH; l++) begin
            if (commit[l].valid) begin
                laneCount = laneCount + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retiredCount <= '0;
            // Identity map out of reset
            for (int n = 0; n < NumNames; n++) begin
                archMap[n] <= `TAG_BITS'(n);
            end
        end else begin
            retiredCount <= retiredCount + laneCount;
            // Higher lane is younger and writes last
            for (int l = 0; l < `ROB_WIDTH; l++) begin
                if (commit[l].valid) begin
                    archMap[commit[l].name] <= commit[l].tag;
                end
            end
        end
    end

    assign readTag = archMap[readName];

    // Lane 1 only retires together with lane 0
    assert property (@(posedge clk) disable iff (rst)
        commit[1].valid |-> commit[0].valid)
    else $error("commit lane 1 valid without lane 0");

endmodule

// ==== rtl/commitTop.sv ====
`timescale 1ns/100ps
`include "rob_defines.svh"

module commitTop import robPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  completion             done [`ROB_WIDTH],
    input  logic                  squash,
    input  logic [`SQN_BITS-1:0]  squashSqN,
    input  logic [`NAME_BITS-1:0] readName,
    output commitSlot             commit [`ROB_WIDTH],
    output logic                  halted,
    output logic [`SQN_BITS-1:0]  curSqN,
    output logic [`SQN_BITS-1:0]  maxSqN,
    output logic [`TAG_BITS-1:0]  readTag,
    output logic [31:0]           retiredCount
);

    // Registered completions, already filtered against squash
    completion staged [`ROB_WIDTH];

    resultIntake intake (
        .clk       (clk),
        .rst       (rst),
        .done      (done),
        .squash    (squash),
        .squashSqN (squashSqN),
        .staged    (staged)
    );

    reorderBuffer rob (
        .clk       (clk),
        .rst       (rst),
        .staged    (staged),
        .squash    (squash),
        .squashSqN (squashSqN),
        .commit    (commit),
        .curSqN    (curSqN),
        .maxSqN    (maxSqN),
        .halted    (halted)
    );

    commitMap archMap (
        .clk          (clk),
        .rst          (rst),
        .commit       (commit),
        .readName     (readName),
        .readTag      (readTag),
        .retiredCount (retiredCount)
    );

endmodule

// ==== tb/tbCommit.sv ====
`timescale 1ns/100ps
`include "rob_defines.svh"

module tbCommit import robPkg::*; ();

    localparam int NumSqN = 2 ** `SQN_BITS;
    localparam int NumNames = 2 ** `NAME_BITS;
    localparam int Timeout = 200;

    typedef enum logic [2:0] {rowIssue, rowSquash, rowDrain, rowDual, rowHalt} rowKind;

    // One step of stimulus with both completion lanes
    typedef struct packed {
        completion            lane0;
        completion            lane1;
        logic                 squash;
        logic [`SQN_BITS-1:0] squashSqN;
        rowKind               kind;
    } stimRow;

    logic                  clk = 1'b0;
    logic                  rst;
    completion             done [`ROB_WIDTH];
    logic                  squash;
    logic [`SQN_BITS-1:0]  squashSqN;
    logic [`NAME_BITS-1:0] readName;
    commitSlot             commit [`ROB_WIDTH];
    logic                  halted;
    logic [`SQN_BITS-1:0]  curSqN;
    logic [`SQN_BITS-1:0]  maxSqN;
    logic [`TAG_BITS-1:0]  readTag;
    logic [31:0]           retiredCount;

    stimRow                stimTable [$];
    logic [15:0]           lfsrState = 16'd75;
    // Reference model of the window and the map
    logic [`NAME_BITS-1:0] expName [NumSqN];
    logic [`TAG_BITS-1:0]  expTag [NumSqN];
    logic                  expFlag [NumSqN];
    logic                  expLive [NumSqN];
    logic [`TAG_BITS-1:0]  modelMap [NumNames];
    logic [`SQN_BITS-1:0]  expNext = '0;
    logic [`SQN_BITS-1:0]  waitTarget = '0;
    int                    modelCount = 0;
    int                    issuedCount = 0;
    logic                  modelHalted = 1'b0;
    retireKind             lastKind = retNone;
    int                    errorCount = 0;

    commitTop dut (.*);

    always #50 clk = ~clk;

    task automatic compareValues(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic abortTimeout(string what);
        $display("timed out while waiting for %s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "wait timed out");
    endtask

    function automatic logic [15:0] lfsrNext(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drawBits(int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
    endtask

    // Signed distance decides program order across wrap
    function automatic logic laterThan(logic [`SQN_BITS-1:0] a, logic [`SQN_BITS-1:0] b);
        logic signed [`SQN_BITS-1:0] d;
        d = a - b;
        return d > 0;
    endfunction

    // Names come from a small set so that some repeat
    task automatic makeLane(int sqN, logic flag, output completion c);
        int nameBits;
        int tagBits;
        drawBits(3, nameBits);
        drawBits(`TAG_BITS, tagBits);
        c = '{valid: 1'b1, flag: flag, tag: `TAG_BITS'(tagBits),
              name: `NAME_BITS'(nameBits), sqN: `SQN_BITS'(sqN)};
    endtask

    task automatic addRow(completion l0, completion l1, rowKind k, int sq);
        stimRow r;
        r.lane0 = l0;
        r.lane1 = l1;
        r.squash = (k == rowSquash);
        r.squashSqN = `SQN_BITS'(sq);
        r.kind = k;
        stimTable.push_back(r);
    endtask

    task automatic buildTable();
        completion blk [8];
        completion tmp;
        completion none;
        int j;
        none = '0;
        for (int i = 0; i < 8; i++) begin
            makeLane(i, 1'b0, blk[i]);
        end
        // Shuffle the first block before issue
        for (int i = 7; i > 0; i--) begin
            drawBits(3, j);
            j = j % (i + 1);
            tmp = blk[i];
            blk[i] = blk[j];
            blk[j] = tmp;
        end
        for (int i = 0; i < 8; i += 2) begin
            addRow(blk[i], blk[i + 1], rowIssue, 0);
        end
        addRow(none, none, rowDrain, 0);
        makeLane(8, 1'b0, blk[0]);
        makeLane(9, 1'b0, blk[1]);
        addRow(blk[0], blk[1], rowIssue, 0);
        addRow(none, none, rowDual, 0);
        // Hole at 12 and a squash of everything past it
        makeLane(10, 1'b0, blk[0]);
        makeLane(11, 1'b0, blk[1]);
        makeLane(13, 1'b0, blk[2]);
        makeLane(14, 1'b0, blk[3]);
        makeLane(15, 1'b0, blk[4]);
        addRow(blk[2], blk[0], rowIssue, 0);
        addRow(blk[4], blk[1], rowIssue, 0);
        addRow(blk[3], none, rowIssue, 0);
        addRow(none, none, rowSquash, 12);
        addRow(none, none, rowDrain, 0);
        // Flagged head followed by work that must never retire
        makeLane(12, 1'b1, blk[0]);
        makeLane(13, 1'b0, blk[1]);
        makeLane(14, 1'b0, blk[2]);
        addRow(blk[0], blk[1], rowIssue, 0);
        addRow(blk[2], none, rowIssue, 0);
        addRow(none, none, rowHalt, 0);
    endtask

    task automatic noteIssue(completion c);
        if (c.valid) begin
            expName[c.sqN] = c.name;
            expTag[c.sqN] = c.tag;
            expFlag[c.sqN] = c.flag;
            expLive[c.sqN] = 1'b1;
            issuedCount++;
            if (laterThan(`SQN_BITS'(c.sqN + 1), waitTarget)) begin
                waitTarget = `SQN_BITS'(c.sqN + 1);
            end
        end
    endtask

    task automatic noteSquash(logic [`SQN_BITS-1:0] sq);
        for (int i = 0; i < NumSqN; i++) begin
            if (expLive[i] && laterThan(`SQN_BITS'(i), sq)) begin
                expLive[i] = 1'b0;
                issuedCount--;
            end
        end
        if (laterThan(waitTarget, sq)) begin
            waitTarget = sq;
        end
    endtask

    task automatic checkMap();
        for (int n = 0; n < NumNames; n++) begin
            @(posedge clk);
            readName <= `NAME_BITS'(n);
            @(negedge clk);
            compareValues($sformatf("readTag[%0d]", n), readTag, modelMap[n]);
        end
    endtask

    task automatic drainWindow();
        int waited;
        waited = 0;
        @(negedge clk);
        while (curSqN !== waitTarget) begin
            waited++;
            if (waited > Timeout) begin
                abortTimeout("the window to drain");
            end
            @(negedge clk);
        end
        // Let the last lanes reach the model and the count
        repeat (2) @(negedge clk);
        compareValues("curSqN", curSqN, waitTarget);
        compareValues("maxSqN", maxSqN, `SQN_BITS'(waitTarget + `ROB_LENGTH - 1));
        compareValues("retiredCount", retiredCount, issuedCount);
        checkMap();
    endtask

    task automatic watchHalt();
        int waited;
        int countAtHalt;
        waited = 0;
        @(negedge clk);
        while (halted !== 1'b1) begin
            waited++;
            if (waited > Timeout) begin
                abortTimeout("halted");
            end
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        countAtHalt = modelCount;
        compareValues("retiredCount", retiredCount, countAtHalt);
        // Monitor rejects any lane seen in this stretch
        repeat (Timeout / 10) @(negedge clk);
        compareValues("retiredCount", retiredCount, countAtHalt);
    endtask

    task automatic applyRow(stimRow r);
        @(posedge clk);
        done[0] <= r.lane0;
        done[1] <= r.lane1;
        squash <= r.squash;
        squashSqN <= r.squashSqN;
        noteIssue(r.lane0);
        noteIssue(r.lane1);
        case (r.kind)
            rowSquash: noteSquash(r.squashSqN);
            rowDrain:  drainWindow();
            rowDual: begin
                drainWindow();
                compareValues("last retire kind", lastKind, retDual);
            end
            rowHalt:   watchHalt();
            default:   ;
        endcase
    endtask

    task automatic checkCommitLane(int l);
        logic [`SQN_BITS-1:0] s;
        s = commit[l].sqN;
        compareValues($sformatf("commit[%0d].valid", l), 1'b1, !modelHalted);
        compareValues($sformatf("commit[%0d].sqN", l), s, expNext);
        compareValues($sformatf("live flag of sqN %0d", s), expLive[s], 1'b1);
        compareValues($sformatf("commit[%0d].name", l), commit[l].name, expName[s]);
        compareValues($sformatf("commit[%0d].tag", l), commit[l].tag, expTag[s]);
        if (expFlag[s]) begin
            compareValues("commit[1].valid", commit[1].valid, 1'b0);
            modelHalted = 1'b1;
        end
        modelMap[expName[s]] = expTag[s];
        expLive[s] = 1'b0;
        modelCount++;
        expNext = expNext + 1'b1;
    endtask

    // Count lags the commit lanes by one edge
    always @(negedge clk) begin
        if (!rst) begin
            compareValues("retiredCount", retiredCount, modelCount);
            compareValues("commit[1].valid without commit[0]",
                          commit[1].valid && !commit[0].valid, 1'b0);
            for (int l = 0; l < `ROB_WIDTH; l++) begin
                if (commit[l].valid) begin
                    checkCommitLane(l);
                end
            end
            if (commit[1].valid) begin
                lastKind = retDual;
            end else if (commit[0].valid) begin
                lastKind = retSingle;
            end
            compareValues("halted", halted, modelHalted);
        end
    end

    initial begin
        rst = 1'b1;
        squash = 1'b0;
        squashSqN = '0;
        readName = '0;
        for (int l = 0; l < `ROB_WIDTH; l++) begin
            done[l] = '0;
        end
        for (int i = 0; i < NumSqN; i++) begin
            expLive[i] = 1'b0;
            expFlag[i] = 1'b0;
        end
        for (int n = 0; n < NumNames; n++) begin
            modelMap[n] = `TAG_BITS'(n);
        end
        buildTable();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compareValues("curSqN", curSqN, 0);
        foreach (stimTable[r]) begin
            applyRow(stimTable[r]);
        end
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/robPkg.sv
rtl/resultIntake.sv
rtl/reorderBuffer.sv
rtl/commitMap.sv
rtl/commitTop.sv
tb/tbCommit.sv
